/* rtl/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Width of the general registers and the pc
`define DATA_WIDTH 32

// Width of a register index
`define REG_ADDR_WIDTH 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// SYSTEM opcode with funct12 of one
`define EBREAK_INST 32'h0010_0073

`endif

/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 for OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_alu_e;

    // funct3 for conditional branches
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } funct3_br_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

endpackage

`default_nettype wire

/* rtl/ctrl_pkg.sv */
`default_nettype none

`include "core_params.svh"

package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY2
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;

    // Five sources, so three bits
    typedef enum logic [2:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR, PC_HOLD} pc_sel_e;

    typedef enum logic {WB_ALU, WB_PC4} wb_sel_e;

    // Decoded controls of the current instruction
    typedef struct packed {
        alu_op_e            alu_op;
        op1_sel_e           op1_sel;
        op2_sel_e           op2_sel;
        pc_sel_e            pc_sel;
        isa_pkg::imm_fmt_e  imm_fmt;
        wb_sel_e            wb_sel;
        logic               rf_we;
        logic               halt;
    } ctrl_t;

    // One retired instruction
    typedef struct packed {
        logic                        valid;
        logic [`DATA_WIDTH-1:0]      pc;
        logic [31:0]                 inst;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic                        rd_we;
        logic [`DATA_WIDTH-1:0]      rd_wdata;
    } commit_t;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module fetch_unit (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire ctrl_pkg::pc_sel_e       pc_sel_i,
    input  wire logic [`DATA_WIDTH-1:0]  br_target_i,
    input  wire logic [`DATA_WIDTH-1:0]  jal_target_i,
    input  wire logic [`DATA_WIDTH-1:0]  jalr_target_i,
    output logic [`DATA_WIDTH-1:0]       pc_o,
    output logic [`DATA_WIDTH-1:0]       pc_plus4_o
);
    import ctrl_pkg::*;

    logic [`DATA_WIDTH-1:0] pc_q;
    logic [`DATA_WIDTH-1:0] pc_next;

    assign pc_plus4_o = pc_q + `DATA_WIDTH'(4);
    assign pc_o       = pc_q;

    always_comb begin
        case (pc_sel_i)
            PC_BRANCH: pc_next = br_target_i;
            PC_JAL:    pc_next = jal_target_i;
            PC_JALR:   pc_next = jalr_target_i;
            PC_HOLD:   pc_next = pc_q;
            default:   pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // Targets from decode must keep fetch on word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module register_file #(
    parameter int ADDR_WIDTH = `REG_ADDR_WIDTH
) (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    we_i,
    input  wire logic [ADDR_WIDTH-1:0]   waddr_i,
    input  wire logic [`DATA_WIDTH-1:0]  wdata_i,
    input  wire logic [ADDR_WIDTH-1:0]   raddr1_i,
    input  wire logic [ADDR_WIDTH-1:0]   raddr2_i,
    output logic [`DATA_WIDTH-1:0]       rdata1_o,
    output logic [`DATA_WIDTH-1:0]       rdata2_o
);

    localparam int NUM_REGS = 2 ** ADDR_WIDTH;

    logic [`DATA_WIDTH-1:0] regs_q [NUM_REGS];

    // x0 is cleared at reset and never written afterwards
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Combinational reads
    assign rdata1_o = regs_q[raddr1_i];
    assign rdata2_o = regs_q[raddr2_i];

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (reset_i)
        ((raddr1_i == '0) |-> (rdata1_o == '0)) and ((raddr2_i == '0) |-> (rdata2_o == '0)));

endmodule

`default_nettype wire

/* rtl/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module decode_unit (
    input  wire logic [31:0]                 inst_i,
    input  wire logic [`DATA_WIDTH-1:0]      pc_i,
    input  wire ctrl_pkg::ctrl_t             ctrl_i,
    input  wire logic [`DATA_WIDTH-1:0]      rs1_data_i,
    input  wire logic [`DATA_WIDTH-1:0]      rs2_data_i,
    output logic [`REG_ADDR_WIDTH-1:0]       rs1_addr_o,
    output logic [`REG_ADDR_WIDTH-1:0]       rs2_addr_o,
    output logic [`REG_ADDR_WIDTH-1:0]       rd_addr_o,
    output logic [`DATA_WIDTH-1:0]           op1_o,
    output logic [`DATA_WIDTH-1:0]           op2_o,
    output logic                             br_eq_o,
    output logic                             br_lt_o,
    output logic                             br_ltu_o,
    output logic [`DATA_WIDTH-1:0]           br_target_o,
    output logic [`DATA_WIDTH-1:0]           jal_target_o,
    output logic [`DATA_WIDTH-1:0]           jalr_target_o
);
    import ctrl_pkg::*;
    import isa_pkg::*;

    logic [`DATA_WIDTH-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [`DATA_WIDTH-1:0] imm;
    logic [`DATA_WIDTH-1:0] jalr_sum;

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    // Sign-extended immediates, one per format
    assign imm_i = {{(`DATA_WIDTH-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{(`DATA_WIDTH-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{(`DATA_WIDTH-13){inst_i[31]}}, inst_i[31], inst_i[7],
                    inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{(`DATA_WIDTH-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                    inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        case (ctrl_i.imm_fmt)
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            default: imm = imm_i;
        endcase
    end

    // Operand muxes
    always_comb begin
        case (ctrl_i.op1_sel)
            OP1_PC:   op1_o = pc_i;
            OP1_ZERO: op1_o = '0;
            default:  op1_o = rs1_data_i;
        endcase
    end

    assign op2_o = (ctrl_i.op2_sel == OP2_IMM) ? imm : rs2_data_i;

    assign br_eq_o  = (rs1_data_i == rs2_data_i);
    assign br_lt_o  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu_o = (rs1_data_i < rs2_data_i);

    assign br_target_o   = pc_i + imm_b;
    assign jal_target_o  = pc_i + imm_j;
    assign jalr_sum      = rs1_data_i + imm_i;
    assign jalr_target_o = {jalr_sum[`DATA_WIDTH-1:1], 1'b0};

endmodule

`default_nettype wire

/* rtl/control_logic.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module control_logic (
    input  wire logic [31:0]         inst_i,
    input  wire logic                br_eq_i,
    input  wire logic                br_lt_i,
    input  wire logic                br_ltu_i,
    output ctrl_pkg::ctrl_t          ctrl_o,
    output ctrl_pkg::pc_sel_e        pc_sel_o
);
    import ctrl_pkg::*;
    import isa_pkg::*;

    opcode_e     opcode;
    funct3_alu_e f3_alu;
    funct3_br_e  f3_br;
    logic [6:0]  funct7;
    logic        op_legal;
    logic        imm_legal;
    logic        br_taken;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign f3_alu = funct3_alu_e'(inst_i[14:12]);
    assign f3_br  = funct3_br_e'(inst_i[14:12]);
    assign funct7 = inst_i[31:25];

    // Only ADD/SUB and SRL/SRA have an alternate funct7
    assign op_legal  = (funct7 == 7'b0000000) ||
                       (funct7 == 7'b0100000 && (f3_alu == F3_ADD || f3_alu == F3_SRL));
    assign imm_legal = !(f3_alu == F3_SLL || f3_alu == F3_SRL) || (funct7 == 7'b0000000) ||
                       (funct7 == 7'b0100000 && f3_alu == F3_SRL);

    function automatic alu_op_e alu_op_from(input funct3_alu_e f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SRL:  op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = alt ? ALU_SUB : ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        // Unknown encodings fall through as a no-op
        ctrl_o = '{alu_op: ALU_ADD, op1_sel: OP1_RS1, op2_sel: OP2_IMM, pc_sel: PC_PLUS4,
                   imm_fmt: IMM_I, wb_sel: WB_ALU, rf_we: 1'b0, halt: 1'b0};
        case (opcode)
            OPC_LUI: begin
                ctrl_o.op1_sel = OP1_ZERO;
                ctrl_o.imm_fmt = IMM_U;
                ctrl_o.alu_op  = ALU_COPY2;
                ctrl_o.rf_we   = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.imm_fmt = IMM_U;
                ctrl_o.rf_we   = 1'b1;
            end
            OPC_JAL: begin
                ctrl_o.imm_fmt = IMM_J;
                ctrl_o.pc_sel  = PC_JAL;
                ctrl_o.wb_sel  = WB_PC4;
                ctrl_o.rf_we   = 1'b1;
            end
            OPC_JALR: begin
                if (inst_i[14:12] == 3'b000) begin
                    ctrl_o.pc_sel = PC_JALR;
                    ctrl_o.wb_sel = WB_PC4;
                    ctrl_o.rf_we  = 1'b1;
                end
            end
            OPC_BRANCH: begin
                ctrl_o.imm_fmt = IMM_B;
                ctrl_o.pc_sel  = PC_BRANCH;
            end
            OPC_OP_IMM: begin
                ctrl_o.alu_op = alu_op_from(f3_alu, inst_i[30] && (f3_alu == F3_SRL));
                ctrl_o.rf_we  = imm_legal;
            end
            OPC_OP: begin
                ctrl_o.op2_sel = OP2_RS2;
                ctrl_o.alu_op  = alu_op_from(f3_alu, inst_i[30]);
                ctrl_o.rf_we   = op_legal;
            end
            OPC_SYSTEM: begin
                if (inst_i == `EBREAK_INST) begin
                    ctrl_o.halt   = 1'b1;
                    ctrl_o.pc_sel = PC_HOLD;
                end
            end
            default: ;
        endcase
    end

    // Branch resolution
    always_comb begin
        case (f3_br)
            BR_BEQ:  br_taken = br_eq_i;
            BR_BNE:  br_taken = !br_eq_i;
            BR_BLT:  br_taken = br_lt_i;
            BR_BGE:  br_taken = !br_lt_i;
            BR_BLTU: br_taken = br_ltu_i;
            BR_BGEU: br_taken = !br_ltu_i;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        pc_sel_o = ctrl_o.pc_sel;
        if (ctrl_o.pc_sel == PC_BRANCH && !br_taken) begin
            pc_sel_o = PC_PLUS4;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module execute_unit (
    input  wire logic [`DATA_WIDTH-1:0]  op1_i,
    input  wire logic [`DATA_WIDTH-1:0]  op2_i,
    input  wire ctrl_pkg::alu_op_e       alu_op_i,
    input  wire ctrl_pkg::wb_sel_e       wb_sel_i,
    input  wire logic [`DATA_WIDTH-1:0]  pc_plus4_i,
    output logic [`DATA_WIDTH-1:0]       wb_data_o
);
    import ctrl_pkg::*;

    localparam int SHAMT_WIDTH = $clog2(`DATA_WIDTH);

    logic [SHAMT_WIDTH-1:0] shamt;
    logic [`DATA_WIDTH-1:0] alu_res;

    // Shift amount from the low bits only
    assign shamt = op2_i[SHAMT_WIDTH-1:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:   alu_res = op1_i + op2_i;
            ALU_SUB:   alu_res = op1_i - op2_i;
            ALU_SLL:   alu_res = op1_i << shamt;
            ALU_SLT:   alu_res = `DATA_WIDTH'($signed(op1_i) < $signed(op2_i));
            ALU_SLTU:  alu_res = `DATA_WIDTH'(op1_i < op2_i);
            ALU_XOR:   alu_res = op1_i ^ op2_i;
            ALU_SRL:   alu_res = op1_i >> shamt;
            ALU_SRA:   alu_res = $unsigned($signed(op1_i) >>> shamt);
            ALU_OR:    alu_res = op1_i | op2_i;
            ALU_AND:   alu_res = op1_i & op2_i;
            ALU_COPY2: alu_res = op2_i;
            default:   alu_res = '0;
        endcase
    end

    // Link value for jumps
    assign wb_data_o = (wb_sel_i == WB_PC4) ? pc_plus4_i : alu_res;

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module rv_core (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    output logic [`DATA_WIDTH-1:0]       imem_addr_o,
    input  wire logic [31:0]             imem_rdata_i,
    output ctrl_pkg::commit_t            commit_o,
    output logic                         halt_o
);
    import ctrl_pkg::*;

    logic [`DATA_WIDTH-1:0]     pc, pc_plus4;
    logic [`DATA_WIDTH-1:0]     br_target, jal_target, jalr_target;
    logic [`DATA_WIDTH-1:0]     op1, op2, wb_data;
    logic [`DATA_WIDTH-1:0]     rs1_data, rs2_data;
    logic [`REG_ADDR_WIDTH-1:0] rs1_addr, rs2_addr, rd_addr;
    logic                       br_eq, br_lt, br_ltu;
    ctrl_t                      ctrl;
    pc_sel_e                    pc_sel;
    logic                       halted_q;
    logic                       retire;

    // Set once the ebreak has retired
    always_ff @(posedge clk) begin
        if (reset_i) begin
            halted_q <= 1'b0;
        end else if (ctrl.halt) begin
            halted_q <= 1'b1;
        end
    end

    assign retire      = !reset_i && !halted_q;
    assign halt_o      = !reset_i && (ctrl.halt || halted_q);
    assign imem_addr_o = pc;

    assign commit_o = '{valid: retire, pc: pc, inst: imem_rdata_i, rd: rd_addr,
                        rd_we: retire && ctrl.rf_we, rd_wdata: wb_data};

    fetch_unit i_fetch_unit (
        .clk(clk), .reset_i(reset_i), .pc_sel_i(pc_sel),
        .br_target_i(br_target), .jal_target_i(jal_target), .jalr_target_i(jalr_target),
        .pc_o(pc), .pc_plus4_o(pc_plus4)
    );

    register_file #(.ADDR_WIDTH(`REG_ADDR_WIDTH)) i_register_file (
        .clk(clk), .reset_i(reset_i), .we_i(retire && ctrl.rf_we),
        .waddr_i(rd_addr), .wdata_i(wb_data),
        .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data)
    );

    decode_unit i_decode_unit (
        .inst_i(imem_rdata_i), .pc_i(pc), .ctrl_i(ctrl),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rd_addr_o(rd_addr),
        .op1_o(op1), .op2_o(op2),
        .br_eq_o(br_eq), .br_lt_o(br_lt), .br_ltu_o(br_ltu),
        .br_target_o(br_target), .jal_target_o(jal_target), .jalr_target_o(jalr_target)
    );

    control_logic i_control_logic (
        .inst_i(imem_rdata_i), .br_eq_i(br_eq), .br_lt_i(br_lt), .br_ltu_i(br_ltu),
        .ctrl_o(ctrl), .pc_sel_o(pc_sel)
    );

    execute_unit i_execute_unit (
        .op1_i(op1), .op2_i(op2), .alu_op_i(ctrl.alu_op), .wb_sel_i(ctrl.wb_sel),
        .pc_plus4_i(pc_plus4), .wb_data_o(wb_data)
    );

    // Halt freezes fetch on the ebreak
    a_halt_holds_pc: assert property (@(posedge clk) disable iff (reset_i)
        halt_o |=> (pc == $past(pc)));

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    // Free-running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module tb_rv_core;
    import ctrl_pkg::*;
    import isa_pkg::*;

    localparam int DW             = `DATA_WIDTH;
    localparam int CLK_PERIOD_NS  = 4;
    localparam int DRIVE_DELAY_NS = 1;
    localparam int RESET_CYCLES   = 10;
    localparam int HOLD_CYCLES    = 5;
    localparam int IMEM_WORDS     = 128;
    localparam int ALU_OPS        = 40;
    localparam int BRANCH_PAIRS   = 6;
    localparam int NUM_TESTS      = 6;
    // Program lengths of the six tests, in test order
    localparam int TOTAL_INSTS    = 4 + (7 * 2 + 2 + ALU_OPS) + 16 + (BRANCH_PAIRS * 16 + 1) + 5 + 11;
    localparam int WATCHDOG_NS    = 2 * CLK_PERIOD_NS *
                                    (TOTAL_INSTS + NUM_TESTS * (RESET_CYCLES + HOLD_CYCLES + 2));

    logic           clk;
    logic           reset_i;
    logic [DW-1:0]  imem_addr_o;
    logic [31:0]    imem_rdata_i;
    commit_t        commit_o;
    logic           halt_o;

    logic [31:0]    prog_mem [IMEM_WORDS];
    int             prog_len;
    int             seed;
    int             error_count;
    int             tests_passed;
    int             tests_failed;

    // Instruction-set model state
    logic [DW-1:0]  model_regs [32];
    logic [DW-1:0]  model_pc;
    logic           model_halted;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) i_clock_gen (.clk_o(clk));

    rv_core i_rv_core (
        .clk(clk), .reset_i(reset_i),
        .imem_addr_o(imem_addr_o), .imem_rdata_i(imem_rdata_i),
        .commit_o(commit_o), .halt_o(halt_o)
    );

    // Anything outside the loaded program reads as ebreak
    function automatic logic [31:0] fetch_word(input logic [DW-1:0] addr);
        logic [31:0] word;
        word = `EBREAK_INST;
        if (addr[1:0] == 2'b00 && (addr >> 2) < prog_len) begin
            word = prog_mem[addr >> 2];
        end
        return word;
    endfunction

    always_comb begin
        imem_rdata_i = fetch_word(imem_addr_o);
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [DW-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                              input logic [DW-1:0] a, input logic [DW-1:0] b);
        logic [4:0]    sh;
        logic [DW-1:0] res;
        sh = b[4:0];
        case (f3)
            F3_ADD:  res = alt ? a - b : a + b;
            F3_SLL:  res = a << sh;
            F3_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
            F3_SLTU: res = (a < b) ? 1 : 0;
            F3_XOR:  res = a ^ b;
            F3_SRL:  res = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            F3_OR:   res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // One step of the ISA model, from the RV32I rules
    function automatic commit_t model_step(input logic [31:0] inst, output logic [DW-1:0] next_pc);
        commit_t       c;
        logic [DW-1:0] rs1v, rs2v, imm_i, imm_b, imm_u, imm_j;
        logic [2:0]    f3;
        logic [6:0]    f7;
        logic          taken;
        rs1v  = model_regs[inst[19:15]];
        rs2v  = model_regs[inst[24:20]];
        f3    = inst[14:12];
        f7    = inst[31:25];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        taken = 1'b0;
        c = '0;
        c.valid = 1'b1;
        c.pc    = model_pc;
        c.inst  = inst;
        c.rd    = inst[11:7];
        next_pc = model_pc + 4;
        case (inst[6:0])
            OPC_LUI: begin
                c.rd_we    = 1'b1;
                c.rd_wdata = imm_u;
            end
            OPC_AUIPC: begin
                c.rd_we    = 1'b1;
                c.rd_wdata = model_pc + imm_u;
            end
            OPC_JAL: begin
                c.rd_we    = 1'b1;
                c.rd_wdata = model_pc + 4;
                next_pc    = model_pc + imm_j;
            end
            OPC_JALR: begin
                if (f3 == 3'b000) begin
                    c.rd_we    = 1'b1;
                    c.rd_wdata = model_pc + 4;
                    next_pc    = (rs1v + imm_i) & ~DW'(1);
                end
            end
            OPC_BRANCH: begin
                case (f3)
                    BR_BEQ:  taken = (rs1v == rs2v);
                    BR_BNE:  taken = (rs1v != rs2v);
                    BR_BLT:  taken = ($signed(rs1v) < $signed(rs2v));
                    BR_BGE:  taken = ($signed(rs1v) >= $signed(rs2v));
                    BR_BLTU: taken = (rs1v < rs2v);
                    BR_BGEU: taken = (rs1v >= rs2v);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = model_pc + imm_b;
                end
            end
            OPC_OP_IMM: begin
                if (!((f3 == F3_SLL && f7 != 7'h00) ||
                      (f3 == F3_SRL && f7 != 7'h00 && f7 != 7'h20))) begin
                    c.rd_we    = 1'b1;
                    c.rd_wdata = alu_ref(f3, f3 == F3_SRL && f7 == 7'h20, rs1v, imm_i);
                end
            end
            OPC_OP: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == F3_ADD || f3 == F3_SRL))) begin
                    c.rd_we    = 1'b1;
                    c.rd_wdata = alu_ref(f3, f7[5], rs1v, rs2v);
                end
            end
            OPC_SYSTEM: begin
                if (inst == `EBREAK_INST) begin
                    next_pc = model_pc;
                end
            end
            default: ;
        endcase
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [DW-1:0] got,
                                   input logic [DW-1:0] exp);
        $display("ERROR at %0t ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
        error_count++;
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got.valid !== exp.valid) report_mismatch("commit_o.valid", got.valid, exp.valid);
        if (got.rd_we !== exp.rd_we) report_mismatch("commit_o.rd_we", got.rd_we, exp.rd_we);
        if (exp.valid) begin
            if (got.pc !== exp.pc) report_mismatch("commit_o.pc", got.pc, exp.pc);
            if (got.inst !== exp.inst) report_mismatch("commit_o.inst", got.inst, exp.inst);
            if (got.rd !== exp.rd) report_mismatch("commit_o.rd", got.rd, exp.rd);
            if (exp.rd_we && got.rd_wdata !== exp.rd_wdata) begin
                report_mismatch("commit_o.rd_wdata", got.rd_wdata, exp.rd_wdata);
            end
        end
    endtask

    task automatic check_pc(input logic [DW-1:0] got, input logic [DW-1:0] exp);
        if (got !== exp) report_mismatch("imem_addr_o", got, exp);
    endtask

    task automatic check_halt(input logic got, input logic exp);
        if (got !== exp) report_mismatch("halt_o", got, exp);
    endtask

    task automatic check_reg(input int idx, input logic [DW-1:0] got, input logic [DW-1:0] exp);
        if (got !== exp) report_mismatch($sformatf("x%0d", idx), got, exp);
    endtask

    // Compare every cycle in mid-cycle, where the combinational outputs have settled
    always @(negedge clk) begin : compare_proc
        commit_t       exp;
        logic [31:0]   inst;
        logic [DW-1:0] next_pc;
        if (reset_i) begin
            for (int r = 0; r < 32; r++) begin
                model_regs[r] = '0;
            end
            model_pc     = `RESET_PC;
            model_halted = 1'b0;
            check_commit(commit_o, '0);
            check_halt(halt_o, 1'b0);
        end else if (model_halted) begin
            check_pc(imem_addr_o, model_pc);
            check_commit(commit_o, '0);
            check_halt(halt_o, 1'b1);
        end else begin
            inst = fetch_word(model_pc);
            exp  = model_step(inst, next_pc);
            check_pc(imem_addr_o, model_pc);
            check_commit(commit_o, exp);
            check_halt(halt_o, inst == `EBREAK_INST);
            if (exp.rd_we && exp.rd != 0) begin
                model_regs[exp.rd] = exp.rd_wdata;
            end
            model_halted = (inst == `EBREAK_INST);
            model_pc     = next_pc;
        end
    end

    task automatic emit(input logic [31:0] word);
        prog_mem[prog_len] = word;
        prog_len++;
    endtask

    // LUI plus ADDI, with the upper part rounded for the signed low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        emit(enc_u(hi[19:0], rd, OPC_LUI));
        emit(enc_i(value[11:0], rd, F3_ADD, rd, OPC_OP_IMM));
    endtask

    task automatic build_reset_prog();
        load_const(1, 32'h1234_5678);
        emit(enc_i(12'd1, 1, F3_ADD, 2, OPC_OP_IMM));
        emit(`EBREAK_INST);
    endtask

    task automatic build_alu_prog();
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        for (int r = 1; r < 8; r++) begin
            load_const(r[4:0], $random(seed));
        end
        emit(enc_i(12'd5, 1, F3_ADD, 0, OPC_OP_IMM));
        for (int n = 0; n < ALU_OPS; n++) begin
            rnd = $random(seed);
            f3  = rnd[2:0];
            alt = rnd[3] && (f3 == F3_ADD || f3 == F3_SRL);
            if (rnd[11]) begin
                emit(enc_r(alt ? 7'h20 : 7'h00, {2'b00, rnd[14:12]}, {2'b00, rnd[10:8]},
                           f3, {1'b0, rnd[7:4]}));
            end else begin
                imm = rnd[31:20];
                if (f3 == F3_SLL || f3 == F3_SRL) begin
                    imm = {(alt && f3 == F3_SRL) ? 7'h20 : 7'h00, rnd[24:20]};
                end
                emit(enc_i(imm, {2'b00, rnd[10:8]}, f3, {1'b0, rnd[7:4]}, OPC_OP_IMM));
            end
        end
        emit(`EBREAK_INST);
    endtask

    task automatic build_jump_prog();
        emit(enc_u(20'hABCDE, 1, OPC_LUI));
        emit(enc_u(20'h00012, 2, OPC_AUIPC));
        emit(enc_j(21'd8, 3));
        emit(enc_i(12'd7, 0, F3_ADD, 4, OPC_OP_IMM));
        // JALR target with bit 0 set, four words ahead
        load_const(5, (prog_len + 4) * 4 + 1);
        emit(enc_i(12'd0, 5, 3'b000, 6, OPC_JALR));
        emit(enc_i(12'd7, 0, F3_ADD, 7, OPC_OP_IMM));
        emit(enc_j(21'd8, 0));
        emit(enc_i(12'd7, 0, F3_ADD, 8, OPC_OP_IMM));
        // Negative offset
        load_const(9, (prog_len + 4) * 4 + 5);
        emit(enc_i(12'hFFC, 9, 3'b000, 10, OPC_JALR));
        emit(enc_i(12'd7, 0, F3_ADD, 8, OPC_OP_IMM));
        emit(enc_i(12'd0, 10, F3_ADD, 11, OPC_OP_IMM));
        emit(`EBREAK_INST);
    endtask

    // x10 counts the branches not taken
    task automatic emit_branch_pair(input logic [31:0] a, input logic [31:0] b);
        load_const(1, a);
        load_const(2, b);
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                emit(enc_b(13'd8, 2, 1, f[2:0]));
                emit(enc_i(12'd1, 10, F3_ADD, 10, OPC_OP_IMM));
            end
        end
    endtask

    task automatic build_branch_prog();
        emit_branch_pair(32'd5, 32'd5);
        emit_branch_pair(32'd5, 32'd6);
        emit_branch_pair(32'hFFFF_FFFF, 32'd1);
        emit_branch_pair(32'd1, 32'hFFFF_FFFF);
        emit_branch_pair(32'h8000_0000, 32'h7FFF_FFFF);
        emit_branch_pair($random(seed), $random(seed));
        emit(`EBREAK_INST);
    endtask

    task automatic build_halt_prog();
        emit(enc_i(12'd3, 0, F3_ADD, 1, OPC_OP_IMM));
        emit(enc_i(12'd4, 0, F3_ADD, 2, OPC_OP_IMM));
        emit(`EBREAK_INST);
        emit(enc_i(12'd9, 0, F3_ADD, 1, OPC_OP_IMM));
        emit(enc_i(12'd1, 0, F3_ADD, 3, OPC_OP_IMM));
    endtask

    task automatic build_unsupported_prog();
        emit(enc_i(12'd1, 0, F3_ADD, 1, OPC_OP_IMM));
        emit(32'h0000_2083);    // lw x1, 0(x0)
        emit(32'h0010_2023);    // sw x1, 0(x0)
        emit(enc_r(7'h01, 2, 1, 3'b000, 1));
        emit(enc_i(12'h401, 1, F3_SLL, 1, OPC_OP_IMM));
        emit(enc_i(12'd0, 1, 3'b001, 1, OPC_JALR));
        emit(enc_b(13'd8, 1, 1, 3'b010));
        emit(32'h0000_0073);    // ecall
        emit(32'h0000_000F);    // fence
        emit(enc_i(12'd0, 1, F3_ADD, 2, OPC_OP_IMM));
        emit(`EBREAK_INST);
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            check_reg(r, i_rv_core.i_register_file.regs_q[r], model_regs[r]);
        end
    endtask

    // Program is loaded while reset holds the core
    task automatic run_test(input int id, input string name);
        int errs_before;
        errs_before = error_count;
        @(posedge clk);
        #(DRIVE_DELAY_NS);
        reset_i  = 1'b1;
        prog_len = 0;
        case (id)
            0: build_reset_prog();
            1: build_alu_prog();
            2: build_jump_prog();
            3: build_branch_prog();
            4: build_halt_prog();
            default: build_unsupported_prog();
        endcase
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY_NS);
        reset_i = 1'b0;
        do begin
            @(negedge clk);
        end while (!halt_o);
        repeat (HOLD_CYCLES) @(negedge clk);
        check_regs();
        if (error_count == errs_before) begin
            tests_passed++;
            $display("Test %-12s passed", name);
        end else begin
            tests_failed++;
            $display("Test %-12s failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout after %0t ns, the core never reached its final halt", $time);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : main
        reset_i      = 1'b1;
        prog_len     = 0;
        seed         = 94629;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        run_test(0, "reset");
        run_test(1, "alu");
        run_test(2, "upper_jump");
        run_test(3, "branch");
        run_test(4, "halt");
        run_test(5, "unsupported");
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/decode_unit.sv
rtl/control_logic.sv
rtl/execute_unit.sv
rtl/rv_core.sv
tb/tb_clock_gen.sv
tb/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_rv_core -f sources.f -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0
